// ==== source/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

    // data path widths
    localparam int word_w_c     = 32;
    localparam int be_w_c       = word_w_c / 8;
    localparam int ram_addr_w_c = 16;

    // number of 32-bit words in the shared RAM
    localparam int ram_depth_c  = 2 ** (ram_addr_w_c - 2);

    typedef logic [word_w_c-1:0]     word_t;
    typedef logic [31:0]             addr_t;
    typedef logic [ram_addr_w_c-1:0] ram_addr_t;
    typedef logic [be_w_c-1:0]       be_t;

    // source of the read data for the response in flight
    typedef enum logic [1:0] {
        RAM,
        PERIPH,
        ERR
    } rsel_e;

    // data port response tracking
    typedef enum logic [1:0] {
        IDLE,
        PERIPH_VALID,
        WAIT_RAM_GNT,
        WAIT_RAM_VALID
    } data_state_e;

endpackage

`default_nettype wire

// ==== source/mem_map_pkg.sv ====
`default_nettype none

package mem_map_pkg;

    // pseudo peripheral addresses on the data port
    localparam logic [31:0] print_addr_c      = 32'h1000_0000;
    localparam logic [31:0] timer_mask_addr_c = 32'h1500_0000;
    localparam logic [31:0] timer_cnt_addr_c  = 32'h1500_0004;
    localparam logic [31:0] status_addr_c     = 32'h2000_0000;
    localparam logic [31:0] exit_addr_c       = 32'h2000_0004;

    // values written to the status register
    localparam logic [31:0] pass_value_c = 32'd123456789;
    localparam logic [31:0] fail_value_c = 32'd1;

    // mask bit position and acknowledge id of the timer interrupt
    localparam int unsigned timer_irq_id_c = 7;

    // returned for reads that hit nothing
    localparam logic [31:0] err_rdata_c = 32'hbadc_0ffe;

endpackage

`default_nettype wire

// ==== source/sp_ram.sv ====
`default_nettype none
`timescale 1ns/1ps

module sp_ram
    import bus_pkg::*;
(
    input  logic      clk_i,
    input  logic      en_i,
    input  logic      we_i,
    input  be_t       be_i,
    input  ram_addr_t addr_i,
    input  word_t     wdata_i,
    output word_t     rdata_o
);

    word_t mem [ram_depth_c];

    logic [ram_addr_w_c-3:0] word_idx;

    // byte address to word index
    assign word_idx = addr_i[ram_addr_w_c-1:2];

    always_ff @(posedge clk_i) begin
        if (en_i) begin
            if (we_i) begin
                for (int b = 0; b < be_w_c; b++) begin
                    if (be_i[b]) begin
                        mem[word_idx][8*b +: 8] <= wdata_i[8*b +: 8];
                    end
                end
            end
            // read data shows up one cycle after the enable
            rdata_o <= mem[word_idx];
        end
    end

endmodule

`default_nettype wire

// ==== source/ram_arbiter.sv ====
`default_nettype none
`timescale 1ns/1ps

module ram_arbiter
    import bus_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_ni,

    // fetch side, read only
    input  logic      instr_req_i,
    input  ram_addr_t instr_addr_i,
    output logic      instr_gnt_o,
    output logic      instr_rvalid_o,
    output word_t     instr_rdata_o,

    // data side
    input  logic      data_req_i,
    input  logic      data_we_i,
    input  be_t       data_be_i,
    input  ram_addr_t data_addr_i,
    input  word_t     data_wdata_i,
    output logic      data_gnt_o,
    output logic      data_rvalid_o,
    output word_t     data_rdata_o,

    // RAM side
    output logic      mem_en_o,
    output logic      mem_we_o,
    output be_t       mem_be_o,
    output ram_addr_t mem_addr_o,
    output word_t     mem_wdata_o,
    input  word_t     mem_rdata_i
);

    logic data_rvalid_q;
    logic instr_rvalid_q;

    // data has fixed priority, a colliding fetch simply waits
    assign data_gnt_o  = data_req_i;
    assign instr_gnt_o = instr_req_i & ~data_req_i;

    // drive the RAM from whichever side won this cycle
    assign mem_en_o    = data_req_i | instr_req_i;
    assign mem_we_o    = data_req_i & data_we_i;
    assign mem_addr_o  = data_req_i ? data_addr_i : instr_addr_i;
    assign mem_wdata_o = data_wdata_i;

    // fetches always read the full word
    assign mem_be_o    = data_req_i ? data_be_i : '1;

    // remember the winner so the response goes back to the right port
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            data_rvalid_q  <= 1'b0;
            instr_rvalid_q <= 1'b0;
        end else begin
            data_rvalid_q  <= data_gnt_o;
            instr_rvalid_q <= instr_gnt_o;
        end
    end

    assign data_rvalid_o  = data_rvalid_q;
    assign instr_rvalid_o = instr_rvalid_q;

    // both ports see the RAM word, rvalid tells who owns it
    assign data_rdata_o   = mem_rdata_i;
    assign instr_rdata_o  = mem_rdata_i;

endmodule

`default_nettype wire

// ==== source/data_decoder.sv ====
`default_nettype none
`timescale 1ns/1ps

module data_decoder
    import bus_pkg::*;
    import mem_map_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_ni,

    // core data port
    input  logic      data_req_i,
    input  logic      data_we_i,
    input  addr_t     data_addr_i,
    input  be_t       data_be_i,
    input  word_t     data_wdata_i,
    output logic      data_gnt_o,
    output logic      data_rvalid_o,
    output word_t     data_rdata_o,

    // towards the arbiter
    output logic      ram_req_o,
    output logic      ram_we_o,
    output be_t       ram_be_o,
    output ram_addr_t ram_addr_o,
    output word_t     ram_wdata_o,
    input  logic      ram_gnt_i,
    input  logic      ram_rvalid_i,
    input  word_t     ram_rdata_i,

    // granted peripheral writes
    output logic      per_wr_o,
    output addr_t     per_addr_o,
    output word_t     per_wdata_o
);

    data_state_e state_d, state_q;
    rsel_e       rsel_d, rsel_q;

    logic is_ram;
    logic is_per_wr;
    logic issue_ok;

    // anything below the RAM size goes to the RAM
    assign is_ram = (data_addr_i[31:ram_addr_w_c] == '0);

    // peripherals are write only, reads from them count as unmapped
    assign is_per_wr = data_we_i &&
                       (data_addr_i == print_addr_c      ||
                        data_addr_i == status_addr_c     ||
                        data_addr_i == exit_addr_c       ||
                        data_addr_i == timer_mask_addr_c ||
                        data_addr_i == timer_cnt_addr_c);

    always_comb begin
        if (is_ram) begin
            rsel_d = RAM;
        end else if (!data_we_i) begin
            rsel_d = ERR;
        end else begin
            // peripheral and unmapped writes answer with zero
            rsel_d = PERIPH;
        end
    end

    // a new request may only go out once the previous RAM word is back
    assign issue_ok = (state_q != WAIT_RAM_VALID) || ram_rvalid_i;

    assign ram_req_o   = data_req_i & is_ram & issue_ok;
    assign ram_we_o    = data_we_i;
    assign ram_be_o    = data_be_i;
    assign ram_addr_o  = data_addr_i[ram_addr_w_c-1:0];
    assign ram_wdata_o = data_wdata_i;

    assign per_wr_o    = data_req_i & is_per_wr & issue_ok;
    assign per_addr_o  = data_addr_i;
    assign per_wdata_o = data_wdata_i;

    always_comb begin
        state_d       = state_q;
        data_gnt_o    = 1'b0;
        data_rvalid_o = 1'b0;

        unique case (state_q)
            PERIPH_VALID:   data_rvalid_o = 1'b1;
            WAIT_RAM_VALID: data_rvalid_o = ram_rvalid_i;
            default: ;
        endcase

        if (issue_ok) begin
            if (data_req_i) begin
                if (is_ram) begin
                    data_gnt_o = ram_gnt_i;
                    state_d    = ram_gnt_i ? WAIT_RAM_VALID : WAIT_RAM_GNT;
                end else begin
                    // peripheral or unmapped, answered by the decoder itself
                    data_gnt_o = 1'b1;
                    state_d    = PERIPH_VALID;
                end
            end else begin
                state_d = IDLE;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            rsel_q  <= RAM;
        end else begin
            state_q <= state_d;
            if (data_gnt_o) begin
                rsel_q <= rsel_d;
            end
        end
    end

    // response data follows the source latched at grant time
    always_comb begin
        unique case (rsel_q)
            RAM:     data_rdata_o = ram_rdata_i;
            ERR:     data_rdata_o = err_rdata_c;
            default: data_rdata_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/periph_regs.sv ====
`default_nettype none
`timescale 1ns/1ps

module periph_regs
    import bus_pkg::*;
    import mem_map_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_ni,

    // granted writes from the decoder
    input  logic       per_wr_i,
    input  addr_t      per_addr_i,
    input  word_t      per_wdata_i,

    // interrupt acknowledge from the core
    input  logic [5:0] irq_id_i,
    input  logic       irq_ack_i,

    output logic       print_valid_o,
    output logic [7:0] print_char_o,
    output logic       tests_passed_o,
    output logic       tests_failed_o,
    output logic       exit_valid_o,
    output word_t      exit_value_o,
    output logic       irq_timer_o
);

    logic  wr_print;
    logic  wr_status;
    logic  wr_exit;
    logic  wr_mask;
    logic  wr_cnt;

    logic  timer_mask_q;
    word_t timer_cnt_q;
    logic  irq_timer_q;
    logic  timer_expire;
    logic  timer_ack;

    // register selects
    assign wr_print  = per_wr_i && (per_addr_i == print_addr_c);
    assign wr_status = per_wr_i && (per_addr_i == status_addr_c);
    assign wr_exit   = per_wr_i && (per_addr_i == exit_addr_c);
    assign wr_mask   = per_wr_i && (per_addr_i == timer_mask_addr_c);
    assign wr_cnt    = per_wr_i && (per_addr_i == timer_cnt_addr_c);

    // single cycle pulses in the cycle of the write
    assign print_valid_o  = wr_print;
    assign print_char_o   = per_wdata_i[7:0];
    assign tests_passed_o = wr_status && (per_wdata_i == pass_value_c);
    assign tests_failed_o = wr_status && (per_wdata_i == fail_value_c);
    assign exit_valid_o   = wr_exit;
    assign exit_value_o   = wr_exit ? per_wdata_i : '0;

    // count reaches zero on this edge, unless a new count lands now
    assign timer_expire = (timer_cnt_q == 32'd1) && !wr_cnt;
    assign timer_ack    = irq_ack_i && (irq_id_i == 6'(timer_irq_id_c));

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            timer_mask_q <= 1'b0;
            timer_cnt_q  <= '0;
            irq_timer_q  <= 1'b0;
        end else begin
            // only the timer bit of the mask matters here
            if (wr_mask) begin
                timer_mask_q <= per_wdata_i[timer_irq_id_c];
            end

            if (wr_cnt) begin
                timer_cnt_q <= per_wdata_i;
            end else if (timer_cnt_q != '0) begin
                timer_cnt_q <= timer_cnt_q - 32'd1;
            end

            // an acknowledge wins over a new expiry in the same cycle
            if (timer_ack) begin
                irq_timer_q <= 1'b0;
            end else if (timer_expire && timer_mask_q) begin
                irq_timer_q <= 1'b1;
            end
        end
    end

    assign irq_timer_o = irq_timer_q;

endmodule

`default_nettype wire

// ==== source/mm_ram.sv ====
`default_nettype none
`timescale 1ns/1ps

module mm_ram
    import bus_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_ni,

    // instruction fetch port
    input  logic       instr_req_i,
    input  addr_t      instr_addr_i,
    output logic       instr_gnt_o,
    output logic       instr_rvalid_o,
    output word_t      instr_rdata_o,

    // data port
    input  logic       data_req_i,
    input  addr_t      data_addr_i,
    input  logic       data_we_i,
    input  be_t        data_be_i,
    input  word_t      data_wdata_i,
    output logic       data_gnt_o,
    output logic       data_rvalid_o,
    output word_t      data_rdata_o,

    // interrupt
    input  logic [5:0] irq_id_i,
    input  logic       irq_ack_i,
    output logic       irq_timer_o,

    // pseudo peripheral outputs
    output logic       print_valid_o,
    output logic [7:0] print_char_o,
    output logic       tests_passed_o,
    output logic       tests_failed_o,
    output logic       exit_valid_o,
    output word_t      exit_value_o
);

    // decoder to arbiter
    logic      ram_req;
    logic      ram_we;
    be_t       ram_be;
    ram_addr_t ram_addr;
    word_t     ram_wdata;
    logic      ram_gnt;
    logic      ram_rvalid;
    word_t     ram_rdata;

    // decoder to peripherals
    logic      per_wr;
    addr_t     per_addr;
    word_t     per_wdata;

    // arbiter to RAM
    logic      mem_en;
    logic      mem_we;
    be_t       mem_be;
    ram_addr_t mem_addr;
    word_t     mem_wdata;
    word_t     mem_rdata;

    data_decoder u_decoder (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .data_req_i    (data_req_i),
        .data_we_i     (data_we_i),
        .data_addr_i   (data_addr_i),
        .data_be_i     (data_be_i),
        .data_wdata_i  (data_wdata_i),
        .data_gnt_o    (data_gnt_o),
        .data_rvalid_o (data_rvalid_o),
        .data_rdata_o  (data_rdata_o),
        .ram_req_o     (ram_req),
        .ram_we_o      (ram_we),
        .ram_be_o      (ram_be),
        .ram_addr_o    (ram_addr),
        .ram_wdata_o   (ram_wdata),
        .ram_gnt_i     (ram_gnt),
        .ram_rvalid_i  (ram_rvalid),
        .ram_rdata_i   (ram_rdata),
        .per_wr_o      (per_wr),
        .per_addr_o    (per_addr),
        .per_wdata_o   (per_wdata)
    );

    periph_regs u_periph (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .per_wr_i       (per_wr),
        .per_addr_i     (per_addr),
        .per_wdata_i    (per_wdata),
        .irq_id_i       (irq_id_i),
        .irq_ack_i      (irq_ack_i),
        .print_valid_o  (print_valid_o),
        .print_char_o   (print_char_o),
        .tests_passed_o (tests_passed_o),
        .tests_failed_o (tests_failed_o),
        .exit_valid_o   (exit_valid_o),
        .exit_value_o   (exit_value_o),
        .irq_timer_o    (irq_timer_o)
    );

    // fetches only ever reach the RAM, so the upper address bits are dropped
    ram_arbiter u_arbiter (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .instr_req_i    (instr_req_i),
        .instr_addr_i   (instr_addr_i[ram_addr_w_c-1:0]),
        .instr_gnt_o    (instr_gnt_o),
        .instr_rvalid_o (instr_rvalid_o),
        .instr_rdata_o  (instr_rdata_o),
        .data_req_i     (ram_req),
        .data_we_i      (ram_we),
        .data_be_i      (ram_be),
        .data_addr_i    (ram_addr),
        .data_wdata_i   (ram_wdata),
        .data_gnt_o     (ram_gnt),
        .data_rvalid_o  (ram_rvalid),
        .data_rdata_o   (ram_rdata),
        .mem_en_o       (mem_en),
        .mem_we_o       (mem_we),
        .mem_be_o       (mem_be),
        .mem_addr_o     (mem_addr),
        .mem_wdata_o    (mem_wdata),
        .mem_rdata_i    (mem_rdata)
    );

    sp_ram u_ram (
        .clk_i   (clk_i),
        .en_i    (mem_en),
        .we_i    (mem_we),
        .be_i    (mem_be),
        .addr_i  (mem_addr),
        .wdata_i (mem_wdata),
        .rdata_o (mem_rdata)
    );

endmodule

`default_nettype wire

// ==== verif/mm_ram_sva.sv ====
`default_nettype none
`timescale 1ns/1ps

module mm_ram_sva
    import bus_pkg::*;
    import mem_map_pkg::*;
(
    input wire logic  clk_i,
    input wire logic  rst_ni,
    input wire logic  instr_gnt_i,
    input wire logic  instr_rvalid_i,
    input wire logic  data_gnt_i,
    input wire logic  data_rvalid_i,
    input wire logic  ram_gnt_i,
    input wire logic  per_wr_i,
    input wire addr_t per_addr_i,
    input wire logic  irq_timer_i
);

    logic cnt_written_q;

    // set once the timer count has been loaded
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cnt_written_q <= 1'b0;
        end else if (per_wr_i && per_addr_i == timer_cnt_addr_c) begin
            cnt_written_q <= 1'b1;
        end
    end

    no_fetch_on_data_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(ram_gnt_i && instr_gnt_i))
        else $error("fetch granted while the data port owns the RAM");

    data_gnt_then_rvalid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        data_gnt_i |=> data_rvalid_i)
        else $error("data grant not followed by rvalid");

    instr_gnt_then_rvalid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        instr_gnt_i |=> instr_rvalid_i)
        else $error("fetch grant not followed by rvalid");

    irq_quiet_before_count: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !cnt_written_q |-> !irq_timer_i)
        else $error("timer interrupt raised before any count write");

endmodule

bind mm_ram mm_ram_sva u_sva (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .instr_gnt_i    (instr_gnt_o),
    .instr_rvalid_i (instr_rvalid_o),
    .data_gnt_i     (data_gnt_o),
    .data_rvalid_i  (data_rvalid_o),
    .ram_gnt_i      (ram_gnt),
    .per_wr_i       (per_wr),
    .per_addr_i     (per_addr),
    .irq_timer_i    (irq_timer_o)
);

`default_nettype wire

// ==== verif/mm_ram_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

module mm_ram_tb
    import bus_pkg::*;
    import mem_map_pkg::*;
;

    localparam int unsigned model_words_c     = 64;
    localparam int unsigned rand_ops_c        = 300;
    // fill, random traffic, directed peripheral accesses and the timer writes
    localparam int unsigned num_ops_c         = model_words_c + rand_ops_c + 12;
    localparam int unsigned op_cycles_c       = 40;
    localparam int unsigned watchdog_cycles_c = 16 + num_ops_c * op_cycles_c;

    logic       clk_i;
    logic       rst_ni;
    logic       instr_req_i;
    addr_t      instr_addr_i;
    logic       instr_gnt_o;
    logic       instr_rvalid_o;
    word_t      instr_rdata_o;
    logic       data_req_i;
    addr_t      data_addr_i;
    logic       data_we_i;
    be_t        data_be_i;
    word_t      data_wdata_i;
    logic       data_gnt_o;
    logic       data_rvalid_o;
    word_t      data_rdata_o;
    logic [5:0] irq_id_i;
    logic       irq_ack_i;
    logic       irq_timer_o;
    logic       print_valid_o;
    logic [7:0] print_char_o;
    logic       tests_passed_o;
    logic       tests_failed_o;
    logic       exit_valid_o;
    word_t      exit_value_o;

    // reference model state
    word_t       model_mem [model_words_c];
    word_t       data_exp_q [$];
    logic        data_chk_q [$];
    word_t       instr_exp_q [$];
    word_t       lfsr_q;
    int unsigned error_count;
    int unsigned collisions;
    logic        data_done;
    word_t       mon_word;
    logic        mon_chk;

    mm_ram dut0 (.*);

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // fibonacci LFSR, taps 32 22 2 1, one step per bit taken
    function automatic word_t take_bits(input int n);
        word_t r;
        logic  fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb    = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            r     = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic report_value(input string name, input word_t exp, input word_t act);
        $display("[ERROR] %s expected %h got %h", name, exp, act);
        error_count++;
    endtask

    task automatic report_fail(input string msg);
        $display("%s", msg);
        error_count++;
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            report_value(name, {31'h0, exp}, {31'h0, act});
        end
    endtask

    // pulses are combinational in the cycle of the granted write
    task automatic check_pulses(input logic we, input addr_t addr, input word_t wdata);
        logic exp_print;
        logic exp_exit;
        exp_print = we && (addr == print_addr_c);
        exp_exit  = we && (addr == exit_addr_c);
        check_bit("print_valid_o", exp_print, print_valid_o);
        if (exp_print && print_char_o !== wdata[7:0]) begin
            report_value("print_char_o", {24'h0, wdata[7:0]}, {24'h0, print_char_o});
        end
        check_bit("tests_passed_o",
                  we && addr == status_addr_c && wdata == pass_value_c, tests_passed_o);
        check_bit("tests_failed_o",
                  we && addr == status_addr_c && wdata == fail_value_c, tests_failed_o);
        check_bit("exit_valid_o", exp_exit, exit_valid_o);
        if (exit_value_o !== (exp_exit ? wdata : 32'h0)) begin
            report_value("exit_value_o", exp_exit ? wdata : 32'h0, exit_value_o);
        end
    endtask

    // starts on a rising edge and returns on the edge after the grant
    task automatic data_op(input logic we, input addr_t addr, input be_t be, input word_t wdata);
        logic [5:0] idx;
        idx = addr[7:2];
        data_req_i   <= 1'b1;
        data_we_i    <= we;
        data_addr_i  <= addr;
        data_be_i    <= be;
        data_wdata_i <= wdata;
        @(negedge clk_i);
        while (!data_gnt_o) begin
            @(negedge clk_i);
        end
        check_pulses(we, addr, wdata);
        if (addr[31:16] == 16'h0) begin
            if (we) begin
                for (int b = 0; b < 4; b++) begin
                    if (be[b]) begin
                        model_mem[idx][8*b +: 8] = wdata[8*b +: 8];
                    end
                end
            end
            data_exp_q.push_back(model_mem[idx]);
            data_chk_q.push_back(!we);
        end else begin
            // writes outside RAM answer zero, reads answer the error word
            data_exp_q.push_back(we ? 32'h0 : err_rdata_c);
            data_chk_q.push_back(1'b1);
        end
        @(posedge clk_i);
    endtask

    task automatic fetch_op(input logic [5:0] idx);
        instr_req_i  <= 1'b1;
        instr_addr_i <= {24'h0, idx, 2'b00};
        @(negedge clk_i);
        while (!instr_gnt_o) begin
            @(negedge clk_i);
        end
        instr_exp_q.push_back(model_mem[idx]);
        @(posedge clk_i);
    endtask

    task automatic timer_check(input logic mask_on, input int unsigned count);
        logic exp_irq;
        data_op(1'b1, timer_mask_addr_c, 4'hf, mask_on ? (32'h1 << timer_irq_id_c) : 32'h0);
        data_op(1'b1, timer_cnt_addr_c, 4'hf, count);
        data_req_i <= 1'b0;
        for (int unsigned k = 1; k <= count + 4; k++) begin
            @(negedge clk_i);
            exp_irq = mask_on && (k >= count + 1);
            check_bit("irq_timer_o", exp_irq, irq_timer_o);
        end
        if (mask_on) begin
            @(posedge clk_i);
            irq_ack_i <= 1'b1;
            irq_id_i  <= 6'(timer_irq_id_c);
            @(negedge clk_i);
            check_bit("irq_timer_o", 1'b1, irq_timer_o);
            @(posedge clk_i);
            irq_ack_i <= 1'b0;
            irq_id_i  <= 6'h0;
            @(negedge clk_i);
            check_bit("irq_timer_o", 1'b0, irq_timer_o);
        end
        @(posedge clk_i);
    endtask

    // responses and arbitration, sampled mid cycle
    always @(negedge clk_i) begin
        if (rst_ni) begin
            if (data_rvalid_o) begin
                if (data_exp_q.size() == 0) begin
                    report_fail("data_rvalid_o came without a pending request");
                end else begin
                    mon_word = data_exp_q.pop_front();
                    mon_chk  = data_chk_q.pop_front();
                    if (mon_chk && data_rdata_o !== mon_word) begin
                        report_value("data_rdata_o", mon_word, data_rdata_o);
                    end
                end
            end
            if (instr_rvalid_o) begin
                if (instr_exp_q.size() == 0) begin
                    report_fail("instr_rvalid_o came without a pending fetch");
                end else begin
                    mon_word = instr_exp_q.pop_front();
                    if (instr_rdata_o !== mon_word) begin
                        report_value("instr_rdata_o", mon_word, instr_rdata_o);
                    end
                end
            end
            if (instr_req_i && data_req_i && data_gnt_o && data_addr_i[31:16] == 16'h0) begin
                if (instr_gnt_o) begin
                    report_fail("fetch was granted together with a data RAM access");
                end else begin
                    collisions++;
                end
            end
            if (!data_req_i && (print_valid_o || tests_passed_o || tests_failed_o ||
                                exit_valid_o)) begin
                report_fail("peripheral pulse seen without a data request");
            end
        end
    end

    initial begin
        repeat (watchdog_cycles_c) @(posedge clk_i);
        $display("watchdog expired before the tests finished");
        $display("Errors found");
        $finish;
    end

    initial begin
        word_t      rnd;
        word_t      wd;
        logic [5:0] idx;
        logic       we;
        be_t        be;
        lfsr_q       = 32'h7087_61ed;
        error_count  = 0;
        collisions   = 0;
        data_done    = 1'b0;
        rst_ni       = 1'b0;
        instr_req_i  = 1'b0;
        instr_addr_i = '0;
        data_req_i   = 1'b0;
        data_addr_i  = '0;
        data_we_i    = 1'b0;
        data_be_i    = '0;
        data_wdata_i = '0;
        irq_id_i     = '0;
        irq_ack_i    = 1'b0;
        repeat (16) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(posedge clk_i);

        // fill the modelled RAM window so every later read is defined
        for (int i = 0; i < int'(model_words_c); i++) begin
            data_op(1'b1, 32'(i * 4), 4'hf, take_bits(32));
        end

        fork
            begin
                for (int i = 0; i < int'(rand_ops_c); i++) begin
                    rnd = take_bits(2);
                    if (rnd[1:0] == 2'b00) begin
                        data_req_i <= 1'b0;
                        @(posedge clk_i);
                    end
                    rnd = take_bits(11);
                    we  = rnd[10];
                    be  = rnd[9:6];
                    idx = rnd[5:0];
                    wd  = take_bits(32);
                    data_op(we, {24'h0, idx, 2'b00}, be, wd);
                end
                data_req_i <= 1'b0;
                data_done = 1'b1;
            end
            begin
                while (!data_done) begin
                    rnd = take_bits(7);
                    if (rnd[6]) begin
                        fetch_op(rnd[5:0]);
                    end else begin
                        instr_req_i <= 1'b0;
                        @(posedge clk_i);
                    end
                end
                instr_req_i <= 1'b0;
            end
        join

        if (collisions == 0) begin
            report_fail("no fetch ever collided with a data RAM access");
        end

        // peripheral writes
        data_op(1'b1, print_addr_c, 4'hf, 32'h0000_0a41);
        data_op(1'b1, status_addr_c, 4'hf, pass_value_c);
        data_op(1'b1, status_addr_c, 4'hf, fail_value_c);
        data_op(1'b1, status_addr_c, 4'hf, 32'h0000_0055);
        data_op(1'b1, exit_addr_c, 4'hf, take_bits(32));

        // unmapped read, then an unmapped write that aliases RAM word 5
        data_op(1'b0, 32'h3000_0010, 4'hf, 32'h0);
        data_op(1'b1, 32'h0001_0014, 4'hf, 32'hdead_beef);
        data_op(1'b0, 32'h0000_0014, 4'hf, 32'h0);
        data_req_i <= 1'b0;
        @(posedge clk_i);

        rnd = take_bits(5);
        timer_check(1'b1, 32'(rnd[4:0]) + 1);
        rnd = take_bits(5);
        timer_check(1'b0, 32'(rnd[4:0]) + 1);

        repeat (4) @(posedge clk_i);
        if (data_exp_q.size() != 0 || instr_exp_q.size() != 0) begin
            report_fail("responses still outstanding at the end of the run");
        end
        $display("run complete, %0d errors, %0d fetch collisions", error_count, collisions);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
source/bus_pkg.sv
source/mem_map_pkg.sv
source/sp_ram.sv
source/ram_arbiter.sv
source/data_decoder.sv
source/periph_regs.sv
source/mm_ram.sv
verif/mm_ram_sva.sv
verif/mm_ram_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the mm_ram testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module mm_ram_tb \
    -Mdir obj_dir \
    -f list.f

./obj_dir/Vmm_ram_tb | tee sim.log

if grep -q "Errors found" sim.log; then
    echo "simulation failed"
    exit 1
fi

echo "simulation passed"
exit 0
